// File: hw/pattern_pkg.sv
package pattern_pkg;

	// bus width, also the width of the LFSR
	localparam int PATTERN_WIDTH = 32;

	localparam logic [PATTERN_WIDTH-1:0] PATTERN_POLY       = 32'h0040_1003;
	localparam logic [PATTERN_WIDTH-1:0] PATTERN_RESET_SEED = 32'h0000_0001;

	// one full word of shifts per call
	function automatic logic [PATTERN_WIDTH-1:0] advance_pattern(
		input logic [PATTERN_WIDTH-1:0] state);
		logic [PATTERN_WIDTH-1:0] fill;
		fill = state;
		for (int k = 0; k < PATTERN_WIDTH; k++)
			fill = {^(fill & PATTERN_POLY), fill[PATTERN_WIDTH-1:1]};
		return fill;
	endfunction

	typedef struct packed {
		logic [PATTERN_WIDTH-1:0] data;
		logic                     last;
	} rd_beat_t;

	typedef struct packed {
		logic [PATTERN_WIDTH-1:0]   data;
		logic [PATTERN_WIDTH/8-1:0] strb;
		logic                       last;
	} wr_beat_t;

	// beat count minus one
	typedef logic [7:0] burst_len_t;

endpackage

// File: hw/csr_pkg.sv
package csr_pkg;

	//////////////////////////////
	// register map
	//////////////////////////////

	typedef enum logic {
		CSR_STATUS = 1'b0,
		CSR_SEED   = 1'b1
	} csr_addr_t;

	//////////////////////////////
	// status word layout
	//////////////////////////////

	localparam int STATUS_ERR_BIT = 0;
	localparam int STATUS_RD_LSB  = 4;
	localparam int STATUS_WR_LSB  = 20;

	// byte counters wrap at 4K
	typedef logic [11:0] byte_count_t;

endpackage

// File: hw/lfsr_source.sv
`timescale 1ns/10ps

module lfsr_source
	import pattern_pkg::*;
	import csr_pkg::*;
(
	input  logic                     i_clk,
	input  logic                     i_reset,

	input  logic                     i_seed_load,
	input  logic [PATTERN_WIDTH-1:0] i_seed,

	input  logic                     i_req_valid,
	output logic                     o_req_ready,
	input  burst_len_t               i_req_len,

	output logic                     o_valid,
	input  logic                     i_ready,
	output rd_beat_t                 o_beat,

	output byte_count_t              o_rd_bytes
);

	logic                     busy;
	burst_len_t               beats_left;
	logic [PATTERN_WIDTH-1:0] state;
	logic                     push;

	// only one burst in flight
	assign o_req_ready = !busy;
	assign o_valid     = busy;
	assign push        = o_valid && i_ready;

	// last beat once the remaining count hits zero
	assign o_beat = '{data: state, last: (beats_left == '0)};

	//////////////////////////////
	// burst control
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			busy       <= 1'b0;
			beats_left <= '0;
		end
		else if (i_req_valid && o_req_ready)
		begin
			busy       <= 1'b1;
			beats_left <= i_req_len;
		end
		else if (push)
		begin
			if (beats_left == '0)
				busy <= 1'b0;
			else
				beats_left <= beats_left - 1'b1;
		end
	end

	//////////////////////////////
	// pattern state and byte count
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state      <= PATTERN_RESET_SEED;
			o_rd_bytes <= '0;
		end
		else if (i_seed_load)
		begin
			state      <= i_seed;
			o_rd_bytes <= '0;
		end
		else if (push)
		begin
			state      <= advance_pattern(state);
			o_rd_bytes <= o_rd_bytes + byte_count_t'(PATTERN_WIDTH / 8);
		end
	end

	// offered beat holds through a stall
	a_beat_stable: assert property (@(posedge i_clk) disable iff (i_reset)
		o_valid && !i_ready && !i_seed_load |=> o_valid && $stable(o_beat));

endmodule

// File: hw/stream_fifo.sv
`timescale 1ns/10ps

module stream_fifo
#(
	parameter type payload_t  = logic,
	parameter int  FIFO_DEPTH = 4
)
(
	input  logic     i_clk,
	input  logic     i_reset,

	input  logic     i_valid,
	output logic     o_ready,
	input  payload_t i_data,

	output logic     o_valid,
	input  logic     i_ready,
	output payload_t o_data
);

	// depth is a power of two, so pointers wrap on their own
	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	payload_t         mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;
	logic             push;
	logic             pop;

	assign full    = (count == CNT_W'(FIFO_DEPTH));
	assign o_valid = (count != '0);
	// a full FIFO still takes a push when the head leaves in the same cycle
	assign o_ready = !full || i_ready;
	assign push    = i_valid && o_ready;
	assign pop     = o_valid && i_ready;
	assign o_data  = mem[rd_ptr];

	always_ff @(posedge i_clk)
	begin
		if (push)
			mem[wr_ptr] <= i_data;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count;
			endcase
		end
	end

	// occupancy stays within the depth so a wrap from either end shows up
	a_no_overflow: assert property (@(posedge i_clk) disable iff (i_reset)
		count <= CNT_W'(FIFO_DEPTH));

	// stalled head holds until it is taken
	a_head_held: assert property (@(posedge i_clk) disable iff (i_reset)
		o_valid && !i_ready |=> o_valid && $stable(o_data));

	// empty means the pointers have met again
	a_ptr_match: assert property (@(posedge i_clk) disable iff (i_reset)
		count == '0 |-> rd_ptr == wr_ptr);

endmodule

// File: hw/lfsr_checker.sv
`timescale 1ns/10ps

module lfsr_checker
	import pattern_pkg::*;
	import csr_pkg::*;
(
	input  logic                     i_clk,
	input  logic                     i_reset,

	input  logic                     i_seed_load,
	input  logic [PATTERN_WIDTH-1:0] i_seed,

	input  logic                     i_valid,
	output logic                     o_ready,
	input  wr_beat_t                 i_beat,

	output logic                     o_err,
	output byte_count_t              o_wr_bytes,
	output logic [PATTERN_WIDTH-1:0] o_state
);

	localparam int BYTES  = PATTERN_WIDTH / 8;
	localparam int SCNT_W = $clog2(BYTES + 1);

	logic [PATTERN_WIDTH-1:0] expected;
	logic                     mismatch;
	logic [SCNT_W-1:0]        strb_count;
	logic                     pop;

	// never back-pressures, one beat per cycle
	assign o_ready = 1'b1;
	assign pop     = i_valid && o_ready;
	assign o_state = expected;

	//////////////////////////////
	// per-lane compare
	//////////////////////////////

	// disabled lanes are neither compared nor counted
	always_comb
	begin
		mismatch   = 1'b0;
		strb_count = '0;
		for (int k = 0; k < BYTES; k++)
		begin
			if (i_beat.strb[k])
			begin
				strb_count = strb_count + 1'b1;
				if (i_beat.data[8*k +: 8] != expected[8*k +: 8])
					mismatch = 1'b1;
			end
		end
	end

	//////////////////////////////
	// expected state, error, count
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			expected   <= PATTERN_RESET_SEED;
			o_err      <= 1'b0;
			o_wr_bytes <= '0;
		end
		else if (i_seed_load)
		begin
			expected   <= i_seed;
			o_err      <= 1'b0;
			o_wr_bytes <= '0;
		end
		else if (pop)
		begin
			// advances a whole word even for a narrow beat
			expected   <= advance_pattern(expected);
			o_wr_bytes <= o_wr_bytes + byte_count_t'(strb_count);
			if (mismatch)
				o_err <= 1'b1;
		end
	end

endmodule

// File: hw/check_csr.sv
`timescale 1ns/10ps

module check_csr
	import csr_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_reset,

	input  logic        i_csr_valid,
	output logic        o_csr_ready,
	input  logic        i_csr_write,
	input  csr_addr_t   i_csr_addr,
	input  logic [31:0] i_csr_wdata,
	output logic        o_csr_rvalid,
	output logic [31:0] o_csr_rdata,
	input  logic        i_csr_rready,

	output logic        o_seed_load,
	output logic [31:0] o_seed,

	input  logic        i_err,
	input  byte_count_t i_rd_bytes,
	input  byte_count_t i_wr_bytes,
	input  logic [31:0] i_state
);

	logic        accept;
	logic [31:0] rdata_next;

	// one access at a time
	assign o_csr_ready = !o_csr_rvalid;
	assign accept      = i_csr_valid && o_csr_ready;

	// seed lands in source and checker on the accepting edge
	assign o_seed_load = accept && i_csr_write && (i_csr_addr == CSR_SEED);
	assign o_seed      = i_csr_wdata;

	//////////////////////////////
	// read mux
	//////////////////////////////

	// writes answer with zero
	always_comb
	begin
		rdata_next = '0;
		if (!i_csr_write)
		begin
			case (i_csr_addr)
			CSR_STATUS:
			begin
				rdata_next[STATUS_ERR_BIT]                       = i_err;
				rdata_next[STATUS_RD_LSB +: $bits(byte_count_t)] = i_rd_bytes;
				rdata_next[STATUS_WR_LSB +: $bits(byte_count_t)] = i_wr_bytes;
			end
			CSR_SEED:
				rdata_next = i_state;
			default:
				rdata_next = '0;
			endcase
		end
	end

	//////////////////////////////
	// response
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_csr_rvalid <= 1'b0;
		else if (accept)
			o_csr_rvalid <= 1'b1;
		else if (i_csr_rready)
			o_csr_rvalid <= 1'b0;
	end

	always_ff @(posedge i_clk)
	begin
		if (accept)
			o_csr_rdata <= rdata_next;
	end

	// response waits for the host
	a_resp_held: assert property (@(posedge i_clk) disable iff (i_reset)
		o_csr_rvalid && !i_csr_rready |=> o_csr_rvalid && $stable(o_csr_rdata));

endmodule

// File: hw/dma_check_top.sv
`timescale 1ns/10ps

module dma_check_top
	import pattern_pkg::*;
	import csr_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
)
(
	input  logic                       i_clk,
	input  logic                       i_reset,

	// read request and read data
	input  logic                       i_rdreq_valid,
	output logic                       o_rdreq_ready,
	input  burst_len_t                 i_rdreq_len,
	output logic                       o_rd_valid,
	input  logic                       i_rd_ready,
	output logic [PATTERN_WIDTH-1:0]   o_rd_data,
	output logic                       o_rd_last,

	// write data
	input  logic                       i_wr_valid,
	output logic                       o_wr_ready,
	input  logic [PATTERN_WIDTH-1:0]   i_wr_data,
	input  logic [PATTERN_WIDTH/8-1:0] i_wr_strb,
	input  logic                       i_wr_last,

	// register port
	input  logic                       i_csr_valid,
	output logic                       o_csr_ready,
	input  logic                       i_csr_write,
	input  csr_addr_t                  i_csr_addr,
	input  logic [31:0]                i_csr_wdata,
	output logic                       o_csr_rvalid,
	output logic [31:0]                o_csr_rdata,
	input  logic                       i_csr_rready
);

	logic                     seed_load;
	logic [PATTERN_WIDTH-1:0] seed;
	logic                     src_valid;
	logic                     src_ready;
	rd_beat_t                 src_beat;
	rd_beat_t                 rd_beat;
	wr_beat_t                 wr_beat;
	logic                     chk_valid;
	logic                     chk_ready;
	wr_beat_t                 chk_beat;
	logic                     err;
	byte_count_t              rd_bytes;
	byte_count_t              wr_bytes;
	logic [PATTERN_WIDTH-1:0] chk_state;

	assign wr_beat   = '{data: i_wr_data, strb: i_wr_strb, last: i_wr_last};
	assign o_rd_data = rd_beat.data;
	assign o_rd_last = rd_beat.last;

	//////////////////////////////
	// read path
	//////////////////////////////

	lfsr_source u_lfsr_source (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_seed_load (seed_load),
		.i_seed      (seed),
		.i_req_valid (i_rdreq_valid),
		.o_req_ready (o_rdreq_ready),
		.i_req_len   (i_rdreq_len),
		.o_valid     (src_valid),
		.i_ready     (src_ready),
		.o_beat      (src_beat),
		.o_rd_bytes  (rd_bytes)
	);

	stream_fifo #(.payload_t(rd_beat_t), .FIFO_DEPTH(FIFO_DEPTH)) u_rd_fifo (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_valid (src_valid),
		.o_ready (src_ready),
		.i_data  (src_beat),
		.o_valid (o_rd_valid),
		.i_ready (i_rd_ready),
		.o_data  (rd_beat)
	);

	//////////////////////////////
	// write path
	//////////////////////////////

	stream_fifo #(.payload_t(wr_beat_t), .FIFO_DEPTH(FIFO_DEPTH)) u_wr_fifo (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_valid (i_wr_valid),
		.o_ready (o_wr_ready),
		.i_data  (wr_beat),
		.o_valid (chk_valid),
		.i_ready (chk_ready),
		.o_data  (chk_beat)
	);

	lfsr_checker u_lfsr_checker (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_seed_load (seed_load),
		.i_seed      (seed),
		.i_valid     (chk_valid),
		.o_ready     (chk_ready),
		.i_beat      (chk_beat),
		.o_err       (err),
		.o_wr_bytes  (wr_bytes),
		.o_state     (chk_state)
	);

	//////////////////////////////
	// registers
	//////////////////////////////

	check_csr u_check_csr (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_csr_valid  (i_csr_valid),
		.o_csr_ready  (o_csr_ready),
		.i_csr_write  (i_csr_write),
		.i_csr_addr   (i_csr_addr),
		.i_csr_wdata  (i_csr_wdata),
		.o_csr_rvalid (o_csr_rvalid),
		.o_csr_rdata  (o_csr_rdata),
		.i_csr_rready (i_csr_rready),
		.o_seed_load  (seed_load),
		.o_seed       (seed),
		.i_err        (err),
		.i_rd_bytes   (rd_bytes),
		.i_wr_bytes   (wr_bytes),
		.i_state      (chk_state)
	);

endmodule

// File: bench/tb_tasks.svh
//////////////////////////////
// checks and bookkeeping
//////////////////////////////

// compares stop counting once a wait has timed out
task automatic check_value(input string test, input string what,
	input logic [31:0] expected, input logic [31:0] actual);
	if (!aborted)
	begin
		check_count++;
		if (expected !== actual)
		begin
			error_count++;
			$display("** Error %s, %s: expected %h, actual %h", test, what, expected, actual);
		end
	end
endtask

task automatic abort_run(input string what);
	$display("timeout: %s", what);
	aborted = 1'b1;
endtask

task automatic finish_test(input string test, input int errors_before);
	test_count++;
	if (aborted)
		$display("test %s: stopped by a timeout", test);
	else if (error_count == errors_before)
		$display("test %s: ok", test);
	else
		$display("test %s: %0d errors", test, error_count - errors_before);
endtask

// nonzero, an all-zero LFSR state never leaves zero
function automatic logic [31:0] fresh_seed();
	logic [31:0] value;
	value = $random(seed_var);
	return value | 32'h1;
endfunction

//////////////////////////////
// bounded waits
//////////////////////////////

localparam int SEL_CSR_READY  = 0;
localparam int SEL_CSR_RVALID = 1;
localparam int SEL_RDREQ      = 2;
localparam int SEL_WR_READY   = 3;

function automatic logic watched_level(input int sel);
	case (sel)
	SEL_CSR_READY:  watched_level = o_csr_ready;
	SEL_CSR_RVALID: watched_level = o_csr_rvalid;
	SEL_RDREQ:      watched_level = o_rdreq_ready;
	default:        watched_level = o_wr_ready;
	endcase
endfunction

// returns at the falling edge where the signal is high
task automatic wait_level(input int sel, input string what);
	int cycles;
	cycles = 0;
	@(negedge i_clk);
	while (!watched_level(sel) && !aborted)
	begin
		cycles++;
		if (cycles > WAIT_LIMIT)
			abort_run(what);
		else
			@(negedge i_clk);
	end
endtask

//////////////////////////////
// register and stream access
//////////////////////////////

task automatic register_access(input logic write, input csr_addr_t addr,
	input logic [31:0] wdata, output logic [31:0] rdata);
	@(posedge i_clk);
	i_csr_valid <= 1'b1;
	i_csr_write <= write;
	i_csr_addr  <= addr;
	i_csr_wdata <= wdata;
	wait_level(SEL_CSR_READY, "register port never accepted the access");
	@(posedge i_clk);
	i_csr_valid <= 1'b0;
	wait_level(SEL_CSR_RVALID, "register response never arrived");
	rdata = o_csr_rdata;
	@(posedge i_clk);
	i_csr_rready <= 1'b1;
	@(posedge i_clk);
	i_csr_rready <= 1'b0;
endtask

task automatic write_register(input csr_addr_t addr, input logic [31:0] wdata);
	logic [31:0] unused;
	register_access(1'b1, addr, wdata, unused);
endtask

task automatic read_register(input csr_addr_t addr, output logic [31:0] rdata);
	register_access(1'b0, addr, 32'h0, rdata);
endtask

task automatic request_burst(input int beats);
	@(posedge i_clk);
	i_rdreq_valid <= 1'b1;
	i_rdreq_len   <= burst_len_t'(beats - 1);
	wait_level(SEL_RDREQ, "read request never accepted");
	@(posedge i_clk);
	i_rdreq_valid <= 1'b0;
endtask

// a beat seen at the falling edge transfers on the next rising edge
task automatic collect_beats(input int n, input logic stall);
	int          got;
	int          idle;
	logic [31:0] rnd;
	got  = 0;
	idle = 0;
	rd_words.delete();
	rd_lasts.delete();
	while (got < n && !aborted)
	begin
		@(posedge i_clk);
		rnd = $random(seed_var);
		i_rd_ready <= stall ? rnd[0] : 1'b1;
		@(negedge i_clk);
		if (o_rd_valid && i_rd_ready)
		begin
			rd_words.push_back(o_rd_data);
			rd_lasts.push_back(o_rd_last);
			got++;
			idle = 0;
		end
		else if (idle == WAIT_LIMIT)
			abort_run("read data stopped before the burst ended");
		else
			idle++;
	end
	@(posedge i_clk);
	i_rd_ready <= 1'b0;
endtask

task automatic check_burst(input string test, input logic [31:0] seed, input int n);
	logic [31:0] expected;
	expected = seed;
	check_value(test, "beat count", n, rd_words.size());
	for (int i = 0; i < rd_words.size(); i++)
	begin
		check_value(test, "read data", expected, rd_words[i]);
		check_value(test, "read last", 32'(i == n - 1), 32'(rd_lasts[i]));
		expected = next_word(expected);
	end
endtask

task automatic write_beat(input logic [31:0] data, input logic [3:0] strb, input logic last);
	@(posedge i_clk);
	i_wr_valid <= 1'b1;
	i_wr_data  <= data;
	i_wr_strb  <= strb;
	i_wr_last  <= last;
	wait_level(SEL_WR_READY, "write FIFO never accepted a beat");
	@(posedge i_clk);
	i_wr_valid <= 1'b0;
	i_wr_last  <= 1'b0;
endtask

//////////////////////////////
// directed tests
//////////////////////////////

task automatic reset_defaults();
	int          errors_before;
	logic [31:0] rdata;
	errors_before = error_count;
	@(negedge i_clk);
	check_value("reset", "read valid", 0, 32'(o_rd_valid));
	check_value("reset", "response valid", 0, 32'(o_csr_rvalid));
	check_value("reset", "request ready", 1, 32'(o_rdreq_ready));
	check_value("reset", "write ready", 1, 32'(o_wr_ready));
	check_value("reset", "register ready", 1, 32'(o_csr_ready));
	read_register(CSR_STATUS, rdata);
	check_value("reset", "status", 0, rdata);
	read_register(CSR_SEED, rdata);
	check_value("reset", "seed", PATTERN_RESET_SEED, rdata);
	finish_test("reset", errors_before);
endtask

task automatic read_under_backpressure();
	int          errors_before;
	logic [31:0] seed;
	logic [31:0] rdata;
	errors_before = error_count;
	seed = fresh_seed();
	write_register(CSR_SEED, seed);
	request_burst(8);
	collect_beats(8, 1'b1);
	check_burst("read burst", seed, 8);
	read_register(CSR_STATUS, rdata);
	check_value("read burst", "status", status_word(1'b0, 32, 0), rdata);
	finish_test("read burst", errors_before);
endtask

task automatic write_loopback();
	int          errors_before;
	logic [31:0] seed;
	logic [31:0] word;
	logic [31:0] rdata;
	errors_before = error_count;
	seed = fresh_seed();
	write_register(CSR_SEED, seed);
	word = seed;
	for (int i = 0; i < 6; i++)
	begin
		write_beat(word, 4'hf, i == 5);
		word = next_word(word);
	end
	// checker is final FIFO_DEPTH+2 cycles after the last handshake
	repeat (FIFO_DEPTH + 2) @(posedge i_clk);
	read_register(CSR_STATUS, rdata);
	check_value("write loopback", "status", status_word(1'b0, 0, 24), rdata);
	read_register(CSR_SEED, rdata);
	check_value("write loopback", "checker state", word, rdata);
	finish_test("write loopback", errors_before);
endtask

task automatic strobe_lanes();
	int          errors_before;
	int          lanes;
	logic [31:0] seed;
	logic [31:0] word;
	logic [31:0] rdata;
	logic [3:0]  strb_list [4];
	logic [31:0] junk_list [4];
	errors_before = error_count;
	// junk sits only in lanes whose strobe is off
	strb_list = '{4'b0001, 4'b0110, 4'b1000, 4'b1011};
	junk_list = '{32'hff00_0000, 32'h0000_00ff, 32'h00ff_0000, 32'h00ff_0000};
	seed = fresh_seed();
	write_register(CSR_SEED, seed);
	word  = seed;
	lanes = 0;
	for (int i = 0; i < 4; i++)
	begin
		write_beat(word ^ junk_list[i], strb_list[i], 1'b0);
		lanes += $countones(strb_list[i]);
		word = next_word(word);
	end
	repeat (FIFO_DEPTH + 2) @(posedge i_clk);
	read_register(CSR_STATUS, rdata);
	check_value("strobes", "status", status_word(1'b0, 0, lanes), rdata);
	// lane 1 enabled and corrupted
	write_beat(word ^ 32'h0000_5a00, 4'b0010, 1'b1);
	lanes += 1;
	repeat (FIFO_DEPTH + 2) @(posedge i_clk);
	read_register(CSR_STATUS, rdata);
	check_value("strobes", "status after corruption", status_word(1'b1, 0, lanes), rdata);
	finish_test("strobes", errors_before);
endtask

task automatic reseed_clears();
	int          errors_before;
	logic [31:0] seed;
	logic [31:0] rdata;
	errors_before = error_count;
	seed = fresh_seed();
	write_register(CSR_SEED, seed);
	read_register(CSR_STATUS, rdata);
	check_value("reseed", "status", 0, rdata);
	request_burst(1);
	collect_beats(1, 1'b0);
	check_burst("reseed", seed, 1);
	read_register(CSR_STATUS, rdata);
	check_value("reseed", "status after burst", status_word(1'b0, 4, 0), rdata);
	finish_test("reseed", errors_before);
endtask

// File: bench/tb_dma_check.sv
`timescale 1ns/10ps

module tb_dma_check
	import pattern_pkg::*;
	import csr_pkg::*;
();

	localparam int FIFO_DEPTH = 4;
	localparam int WAIT_LIMIT = 200;

	logic        i_clk = 1'b0;
	logic        i_reset;
	logic        i_rdreq_valid;
	logic        o_rdreq_ready;
	burst_len_t  i_rdreq_len;
	logic        o_rd_valid;
	logic        i_rd_ready;
	logic [31:0] o_rd_data;
	logic        o_rd_last;
	logic        i_wr_valid;
	logic        o_wr_ready;
	logic [31:0] i_wr_data;
	logic [3:0]  i_wr_strb;
	logic        i_wr_last;
	logic        i_csr_valid;
	logic        o_csr_ready;
	logic        i_csr_write;
	csr_addr_t   i_csr_addr;
	logic [31:0] i_csr_wdata;
	logic        o_csr_rvalid;
	logic [31:0] o_csr_rdata;
	logic        i_csr_rready;

	integer      seed_var = 32'hee9b;
	int          check_count;
	int          error_count;
	int          test_count;
	logic        aborted;
	logic [31:0] rd_words[$];
	logic        rd_lasts[$];

	// 50 MHz
	always #10 i_clk = ~i_clk;

	dma_check_top #(.FIFO_DEPTH(FIFO_DEPTH)) u_dma_check_top (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_rdreq_valid (i_rdreq_valid),
		.o_rdreq_ready (o_rdreq_ready),
		.i_rdreq_len   (i_rdreq_len),
		.o_rd_valid    (o_rd_valid),
		.i_rd_ready    (i_rd_ready),
		.o_rd_data     (o_rd_data),
		.o_rd_last     (o_rd_last),
		.i_wr_valid    (i_wr_valid),
		.o_wr_ready    (o_wr_ready),
		.i_wr_data     (i_wr_data),
		.i_wr_strb     (i_wr_strb),
		.i_wr_last     (i_wr_last),
		.i_csr_valid   (i_csr_valid),
		.o_csr_ready   (o_csr_ready),
		.i_csr_write   (i_csr_write),
		.i_csr_addr    (i_csr_addr),
		.i_csr_wdata   (i_csr_wdata),
		.o_csr_rvalid  (o_csr_rvalid),
		.o_csr_rdata   (o_csr_rdata),
		.i_csr_rready  (i_csr_rready)
	);

	//////////////////////////////
	// reference model
	//////////////////////////////

	// 32 single-bit shifts, parity of the tapped bits enters at the top
	function automatic logic [31:0] next_word(input logic [31:0] word);
		logic [31:0] w;
		logic        fb;
		w = word;
		for (int s = 0; s < 32; s++)
		begin
			fb = 1'b0;
			for (int b = 0; b < 32; b++)
				if (PATTERN_POLY[b])
					fb = fb ^ w[b];
			w = {fb, w[31:1]};
		end
		return w;
	endfunction

	// err in bit 0, read bytes from bit 4, write bytes from bit 20
	function automatic logic [31:0] status_word(input logic err, input int rd, input int wr);
		return {wr[11:0], 4'h0, rd[11:0], 3'b000, err};
	endfunction

	`include "tb_tasks.svh"

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial
	begin
		i_reset       = 1'b1;
		i_rdreq_valid = 1'b0;
		i_rdreq_len   = '0;
		i_rd_ready    = 1'b0;
		i_wr_valid    = 1'b0;
		i_wr_data     = '0;
		i_wr_strb     = '0;
		i_wr_last     = 1'b0;
		i_csr_valid   = 1'b0;
		i_csr_write   = 1'b0;
		i_csr_addr    = CSR_STATUS;
		i_csr_wdata   = '0;
		i_csr_rready  = 1'b0;
		check_count   = 0;
		error_count   = 0;
		test_count    = 0;
		aborted       = 1'b0;

		repeat (3) @(posedge i_clk);
		i_reset <= 1'b0;

		reset_defaults();
		if (!aborted)
			read_under_backpressure();
		if (!aborted)
			write_loopback();
		if (!aborted)
			strobe_lanes();
		if (!aborted)
			reseed_clears();

		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (aborted || error_count != 0)
			$display("SIMULATION FAILED");
		else
			$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: tb.f
hw/pattern_pkg.sv
hw/csr_pkg.sv
hw/lfsr_source.sv
hw/stream_fifo.sv
hw/lfsr_checker.sv
hw/check_csr.sv
hw/dma_check_top.sv
+incdir+bench
bench/tb_dma_check.sv

// File: run.sh
#!/bin/sh
# build the DMA checker testbench with Verilator, run it,
# and judge the run by the pass line in the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_dma_check -f tb.f -o tb_dma_check &&
	./obj_dir/tb_dma_check > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "SIMULATION PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
